//--- icache.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_rd_if.sv
hdl/icache_tag_bank.sv
hdl/icache_data_bank.sv
hdl/icache_array_stage.sv
hdl/icache_hit_stage.sv
hdl/icache.sv
tests/icache_props.sv
tests/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the icache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -f icache.f -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/icache_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

//--- tests/icache_tb.sv
/* icache lookup testbench */
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();
    localparam logic [1:0] K_IDLE  = 2'd0;
    localparam logic [1:0] K_LOOK  = 2'd1;
    localparam logic [1:0] K_FILL  = 2'd2;
    localparam logic [1:0] K_FLUSH = 2'd3;

    // table row where req_too also issues a lookup of the fill address
    typedef struct packed {
        logic [1:0] kind;
        addr_t      addr;
        logic       req_too;
    } op_t;

    typedef struct packed {
        logic   hit;
        instr_t instr;
    } exp_t;

    logic   clk = 1'b0;
    logic   rst;
    logic   req;
    addr_t  pc;
    logic   fill;
    addr_t  fill_addr;
    block_t fill_data;
    logic   flush;
    logic   rsp_valid;
    logic   hit;
    instr_t instr;

    op_t         ops [$];
    exp_t        exp_q [$];
    logic [31:0] lfsr_state;
    logic [1:0]  req_hist;
    // reference model of tags, valid bits, lru and blocks
    tag_t        m_tag [2][64];
    logic [63:0] m_valid [2];
    logic [63:0] m_lru;
    block_t      m_data [2][64];
    // touch of the previous lookup lands one edge later
    logic        p_touch;
    set_t        p_set;
    way_t        p_way;

    icache dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .pc        (pc),
        .fill      (fill),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .flush     (flush),
        .rsp_valid (rsp_valid),
        .hit       (hit),
        .instr     (instr)
    );

    always #10 clk = ~clk;

    function automatic addr_t mk_addr(tag_t tag, set_t set, word_sel_t word);
        return {tag, set, word, 2'b00};
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic make_block(output block_t blk);
        blk = '0;
        repeat (64) begin
            lfsr_state = lfsr_next(lfsr_state);
            blk = {lfsr_state[0], blk[63:1]};
        end
    endtask

    task automatic stop_failed();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_hit(logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: hit got %b expected %b", $time, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_valid(logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: rsp_valid got %b expected %b", $time, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_instr(instr_t got, instr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: instr got %h expected %h", $time, got, exp);
            stop_failed();
        end
    endtask

    task automatic add_op(logic [1:0] kind, addr_t addr, logic req_too);
        op_t o;
        o.kind    = kind;
        o.addr    = addr;
        o.req_too = req_too;
        ops.push_back(o);
    endtask

    // one row per edge with the lookup reading state before this edge's writes
    task automatic model_step(op_t op, block_t blk);
        tag_t      t;
        set_t      s;
        word_sel_t ws;
        logic      looking;
        logic      h;
        way_t      hw;
        way_t      fw;
        exp_t      e;
        t       = op.addr[31:9];
        s       = op.addr[8:3];
        ws      = op.addr[2];
        looking = (op.kind == K_LOOK) || op.req_too;
        h       = 1'b0;
        hw      = 1'b0;
        if (m_valid[0][s] && m_tag[0][s] == t) begin
            h  = 1'b1;
            hw = 1'b0;
        end
        if (m_valid[1][s] && m_tag[1][s] == t) begin
            h  = 1'b1;
            hw = 1'b1;
        end
        if (looking) begin
            e.hit   = h;
            e.instr = ws ? m_data[hw][s][63:32] : m_data[hw][s][31:0];
            exp_q.push_back(e);
        end
        // refill way uses the lru before this edge's update
        if (m_valid[0][s] && m_tag[0][s] == t) begin
            fw = 1'b0;
        end else if (m_valid[1][s] && m_tag[1][s] == t) begin
            fw = 1'b1;
        end else if (!m_valid[0][s]) begin
            fw = 1'b0;
        end else if (!m_valid[1][s]) begin
            fw = 1'b1;
        end else begin
            fw = m_lru[s];
        end
        if (p_touch) begin
            m_lru[p_set] = ~p_way;
        end
        if (op.kind == K_FLUSH) begin
            m_valid[0] = '0;
            m_valid[1] = '0;
        end else if (op.kind == K_FILL) begin
            m_tag[fw][s]   = t;
            m_valid[fw][s] = 1'b1;
            m_data[fw][s]  = blk;
            m_lru[s]       = ~fw;
        end
        p_touch = looking && h;
        p_set   = s;
        p_way   = hw;
    endtask

    task automatic drive_op(op_t op);
        block_t blk;
        blk = '0;
        if (op.kind == K_FILL) begin
            make_block(blk);
        end
        req       <= (op.kind == K_LOOK) || op.req_too;
        pc        <= op.addr;
        fill      <= (op.kind == K_FILL);
        fill_addr <= op.addr;
        fill_data <= blk;
        flush     <= (op.kind == K_FLUSH);
        model_step(op, blk);
    endtask

    task automatic build_table();
        // cold cache lookups back to back and with a gap
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b1), 1'b0);
        add_op(K_LOOK, mk_addr(23'd2, 6'd7, 1'b0), 1'b0);
        add_op(K_IDLE, '0, 1'b0);
        add_op(K_LOOK, mk_addr(23'd3, 6'd9, 1'b1), 1'b0);
        // one block read back in both words
        add_op(K_FILL, mk_addr(23'd1, 6'd5, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b1), 1'b0);
        // set 7 eviction where the hit on tag 2 saves way 0
        add_op(K_FILL, mk_addr(23'd2, 6'd7, 1'b0), 1'b0);
        add_op(K_FILL, mk_addr(23'd3, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd2, 6'd7, 1'b0), 1'b0);
        add_op(K_IDLE, '0, 1'b0);
        add_op(K_FILL, mk_addr(23'd4, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd3, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd2, 6'd7, 1'b1), 1'b0);
        add_op(K_LOOK, mk_addr(23'd4, 6'd7, 1'b0), 1'b0);
        add_op(K_IDLE, '0, 1'b0);
        add_op(K_FILL, mk_addr(23'd5, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd2, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd5, 6'd7, 1'b1), 1'b0);
        add_op(K_LOOK, mk_addr(23'd4, 6'd7, 1'b1), 1'b0);
        add_op(K_IDLE, '0, 1'b0);
        // tag 4 refilled in place while the lru names the other way
        add_op(K_FILL, mk_addr(23'd4, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd4, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd5, 6'd7, 1'b0), 1'b0);
        // flush then refill
        add_op(K_FLUSH, '0, 1'b0);
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd4, 6'd7, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd5, 6'd7, 1'b1), 1'b0);
        add_op(K_FILL, mk_addr(23'd1, 6'd5, 1'b0), 1'b0);
        add_op(K_LOOK, mk_addr(23'd1, 6'd5, 1'b1), 1'b0);
        // lookup alongside its own fill misses and the next one hits
        add_op(K_FILL, mk_addr(23'd6, 6'd20, 1'b0), 1'b1);
        add_op(K_LOOK, mk_addr(23'd6, 6'd20, 1'b1), 1'b0);
    endtask

    // responses checked on the falling edge
    always @(negedge clk) begin : check_rsp
        exp_t e;
        if (!rst) begin
            check_valid(rsp_valid, req_hist[1]);
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response seen at %0t with no lookup outstanding", $time);
                    stop_failed();
                end
                e = exp_q.pop_front();
                check_hit(hit, e.hit);
                if (e.hit) begin
                    check_instr(instr, e.instr);
                end
            end
        end
        req_hist = {req_hist[0], req};
    end

    initial begin : run_test
        op_t idle;
        int  waited;
        rst        = 1'b1;
        req        = 1'b0;
        pc         = '0;
        fill       = 1'b0;
        fill_addr  = '0;
        fill_data  = '0;
        flush      = 1'b0;
        req_hist   = '0;
        lfsr_state = 32'd91;
        m_valid[0] = '0;
        m_valid[1] = '0;
        m_lru      = '0;
        p_touch    = 1'b0;
        p_set      = '0;
        p_way      = 1'b0;
        idle       = '0;
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        foreach (ops[i]) begin
            @(posedge clk);
            drive_op(ops[i]);
        end
        @(posedge clk);
        drive_op(idle);
        // drain the pipe
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d responses still missing", exp_q.size());
            stop_failed();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end
endmodule

`default_nettype wire

//--- tests/icache_props.sv
/* icache pipeline assertions */
`timescale 1ns/1ps
`default_nettype none

module icache_props (
    input logic       clk,
    input logic       rst,
    input logic       req,
    input logic       rsp_valid,
    input logic       lookup_valid,
    input logic [1:0] way_sel
);
    // response strobe cleared by reset
    a_rst_clears: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high after reset");

    // fixed two cycle latency once reset is two edges back
    a_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(rst, 2) |-> rsp_valid == $past(req, 2))
        else $error("rsp_valid does not follow req by two cycles");

    // a tag lives in at most one way of a set
    a_one_hot: assert property (@(posedge clk) disable iff (rst)
        lookup_valid |-> !(way_sel[0] && way_sel[1]))
        else $error("both ways selected in the hit stage");
endmodule

bind icache icache_props u_props (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .rsp_valid    (rsp_valid),
    .lookup_valid (rd_if.valid),
    .way_sel      (u_hit.way_sel)
);

`default_nettype wire

//--- hdl/icache.sv
/* two-way icache lookup */
`timescale 1ns/1ps
`default_nettype none

module icache import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    // fetch request
    input  logic   req,
    input  addr_t  pc,
    // refill from outside
    input  logic   fill,
    input  addr_t  fill_addr,
    input  block_t fill_data,
    input  logic   flush,
    // response, two cycles after req
    output logic   rsp_valid,
    output logic   hit,
    output instr_t instr
);
    // lru touch back from the hit stage
    logic touch;
    set_t touch_set;
    way_t touch_way;

    icache_rd_if rd_if ();

    icache_array_stage u_array (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .pc        (pc),
        .fill      (fill),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .flush     (flush),
        .touch     (touch),
        .touch_set (touch_set),
        .touch_way (touch_way),
        .rd        (rd_if.src)
    );

    icache_hit_stage u_hit (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd_if.dst),
        .touch     (touch),
        .touch_set (touch_set),
        .touch_way (touch_way),
        .rsp_valid (rsp_valid),
        .hit       (hit),
        .instr     (instr)
    );
endmodule

`default_nettype wire

//--- hdl/icache_hit_stage.sv
/* icache hit stage */
`timescale 1ns/1ps
`default_nettype none

module icache_hit_stage import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    icache_rd_if.dst rd,
    output logic   touch,
    output set_t   touch_set,
    output way_t   touch_way,
    output logic   rsp_valid,
    output logic   hit,
    output instr_t instr
);
    localparam int INSTR_W = $bits(instr_t);

    // one-hot way select, at most one way holds a given tag
    logic [1:0] way_sel;
    logic       any_hit;
    block_t     sel_block;
    instr_t     sel_instr;

    // tag compare qualified by the valid bit
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_sel[w] = rd.way_valid[w] && (rd.way_tag[w] == rd.req_tag);
        end
    end

    assign any_hit = |way_sel;

    // and-or mux, zero when nothing matches
    assign sel_block = ({$bits(block_t){way_sel[0]}} & rd.way_data[0])
                     | ({$bits(block_t){way_sel[1]}} & rd.way_data[1]);

    // low word is instruction 0
    assign sel_instr = sel_block[rd.word_sel * INSTR_W +: INSTR_W];

    // lru touch lands on the same edge as rsp_valid
    assign touch     = rd.valid && any_hit;
    assign touch_set = rd.set;
    assign touch_way = way_t'(way_sel[1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            rsp_valid <= rd.valid;
            hit       <= rd.valid && any_hit;
        end
    end

    // instruction is only meaningful with hit
    always_ff @(posedge clk) begin
        instr <= sel_instr;
    end
endmodule

`default_nettype wire

//--- hdl/icache_array_stage.sv
/* icache array stage */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_array_stage import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  addr_t  pc,
    input  logic   fill,
    input  addr_t  fill_addr,
    input  block_t fill_data,
    input  logic   flush,
    input  logic   touch,
    input  set_t   touch_set,
    input  way_t   touch_way,
    icache_rd_if.src rd
);
    set_t       pc_set;
    tag_t       fill_tag;
    set_t       fill_set;
    logic       fill_wr;
    way_t       fill_way;
    logic [1:0] way_wr;
    logic [1:0] rd_v;
    tag_t [1:0] rd_tag;
    block_t [1:0] rd_data;
    logic [1:0] chk_v;
    tag_t [1:0] chk_tag;
    // one bit per set, names the way to replace next
    logic [`ICACHE_SETS-1:0] lru;

    assign pc_set   = addr_set(pc);
    assign fill_tag = addr_tag(fill_addr);
    assign fill_set = addr_set(fill_addr);
    // flush beats a fill in the same cycle
    assign fill_wr  = fill && !flush;

    // refill way: matching tag, then invalid way 0, invalid way 1, then lru
    always_comb begin
        if (chk_v[0] && chk_tag[0] == fill_tag) begin
            fill_way = 1'b0;
        end else if (chk_v[1] && chk_tag[1] == fill_tag) begin
            fill_way = 1'b1;
        end else if (!chk_v[0]) begin
            fill_way = 1'b0;
        end else if (!chk_v[1]) begin
            fill_way = 1'b1;
        end else begin
            fill_way = lru[fill_set];
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_wr[w] = fill_wr && (fill_way == way_t'(w));

        icache_tag_bank u_tag (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .wr        (way_wr[w]),
            .wr_set    (fill_set),
            .wr_tag    (fill_tag),
            .rd_set    (pc_set),
            .rd_valid  (rd_v[w]),
            .rd_tag    (rd_tag[w]),
            .chk_set   (fill_set),
            .chk_valid (chk_v[w]),
            .chk_tag   (chk_tag[w])
        );

        icache_data_bank u_data (
            .clk     (clk),
            .wr      (way_wr[w]),
            .wr_set  (fill_set),
            .wr_data (fill_data),
            .rd_set  (pc_set),
            .rd_data (rd_data[w])
        );
    end

    // hit touch first, a fill to the same set overrides it
    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else begin
            if (touch) begin
                lru[touch_set] <= ~touch_way;
            end
            if (fill_wr) begin
                lru[fill_set] <= ~fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd.valid <= 1'b0;
        end else begin
            rd.valid <= req;
        end
    end

    // read-out payload, qualified downstream by rd.valid
    always_ff @(posedge clk) begin
        rd.req_tag   <= addr_tag(pc);
        rd.word_sel  <= addr_word(pc);
        rd.set       <= pc_set;
        rd.way_valid <= rd_v;
        rd.way_tag   <= rd_tag;
        rd.way_data  <= rd_data;
    end
endmodule

`default_nettype wire

//--- hdl/icache_data_bank.sv
/* icache data bank */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_data_bank import icache_pkg::*; (
    input  logic   clk,
    input  logic   wr,
    input  set_t   wr_set,
    input  block_t wr_data,
    input  set_t   rd_set,
    output block_t rd_data
);
    // one block per set
    block_t blocks [`ICACHE_SETS];

    // whole block written on refill
    always_ff @(posedge clk) begin
        if (wr) begin
            blocks[wr_set] <= wr_data;
        end
    end

    // async read, registered by the array stage
    assign rd_data = blocks[rd_set];
endmodule

`default_nettype wire

//--- hdl/icache_tag_bank.sv
/* icache tag bank */
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_tag_bank import icache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic wr,
    input  set_t wr_set,
    input  tag_t wr_tag,
    // lookup port
    input  set_t rd_set,
    output logic rd_valid,
    output tag_t rd_tag,
    // second port, used to check a fill against the bank
    input  set_t chk_set,
    output logic chk_valid,
    output tag_t chk_tag
);
    tag_t tags [`ICACHE_SETS];
    // valid bits live in flops so a flush clears them in one edge
    logic [`ICACHE_SETS-1:0] valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else if (wr) begin
            valid[wr_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            tags[wr_set] <= wr_tag;
        end
    end

    // both reads see the contents before this edge's write
    assign rd_valid  = valid[rd_set];
    assign rd_tag    = tags[rd_set];
    assign chk_valid = valid[chk_set];
    assign chk_tag   = tags[chk_set];
endmodule

`default_nettype wire

//--- hdl/icache_rd_if.sv
/* icache set read-out */
`timescale 1ns/1ps
`default_nettype none

interface icache_rd_if import icache_pkg::*; ();
    // lookup in flight, registered in stage one
    logic       valid;
    tag_t       req_tag;
    word_sel_t  word_sel;
    // set is passed on for the lru touch
    set_t       set;
    // both ways of the addressed set
    logic [1:0] way_valid;
    tag_t [1:0] way_tag;
    block_t [1:0] way_data;

    // array stage side
    modport src (
        output valid,
        output req_tag,
        output word_sel,
        output set,
        output way_valid,
        output way_tag,
        output way_data
    );

    // hit stage side
    modport dst (
        input valid,
        input req_tag,
        input word_sel,
        input set,
        input way_valid,
        input way_tag,
        input way_data
    );
endinterface

`default_nettype wire

//--- hdl/icache_pkg.sv
/* icache shared types */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;
    // byte offset within a block, then set index, rest is tag
    localparam int OFF_W = $clog2(`ICACHE_BLOCK_W / 8);
    localparam int SET_W = $clog2(`ICACHE_SETS);
    localparam int TAG_W = `ICACHE_ADDR_W - SET_W - OFF_W;

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]           tag_t;
    typedef logic [SET_W-1:0]           set_t;
    // picks instruction 0 (low word) or 1 (high word)
    typedef logic                       word_sel_t;
    typedef logic [`ICACHE_BLOCK_W-1:0] block_t;
    typedef logic [`ICACHE_INSTR_W-1:0] instr_t;
    typedef logic                       way_t;

    // address field helpers, same split for fetch and fill
    function automatic tag_t addr_tag(addr_t a);
        return a[`ICACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic set_t addr_set(addr_t a);
        return a[OFF_W +: SET_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[OFF_W-1];
    endfunction
endpackage

`default_nettype wire

//--- hdl/icache_consts.svh
/* icache geometry constants */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch and fill address width in bits
`define ICACHE_ADDR_W 32

// one block is two instructions
`define ICACHE_BLOCK_W 64

// sets per way, one lru bit each
`define ICACHE_SETS 64

// instruction word width
`define ICACHE_INSTR_W 32

`endif
